/* Bender.yml */
package:
  name: keypad_ctrl

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/keypad_pkg.sv
      - common/apb_pkg.sv
      - keypad/keypad_scan.sv
      - keypad/key_debounce.sv
      - rtl/key_fifo.sv
      - rtl/keypad_ctrl.sv
      - rtl/keypad_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/keypad_matrix_model.sv
      - testbench/tb_keypad_top.sv

/* common/apb_pkg.sv */
// ----------------------------
// apb3 subset, no wait states, no pprot or pstrb
// ----------------------------
`default_nettype none

package apb_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;   // byte offset
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  // decoded register
  typedef enum logic [1:0] {
    ctrl   = 2'd0,
    status = 2'd1,
    data   = 2'd2,
    none   = 2'd3  // unmapped offset
  } reg_sel_e;

endpackage

`default_nettype wire

/* common/keypad_defs.svh */
// ----------------------------
// sizes are fixed for a 4x3 phone keypad; the scan code map assumes 4 rows, 3 cols
// ----------------------------
`ifndef KEYPAD_DEFS_SVH
`define KEYPAD_DEFS_SVH

// matrix
`define KP_ROWS        4
`define KP_COLS        3

// timing, dwell in clocks (min 2), debounce in whole sweeps
`define KP_DWELL       4
`define KP_DEBOUNCE    3

// event queue
`define KP_FIFO_DEPTH  4
`define KP_FIFO_AW     2

// apb register offsets
`define KP_REG_CTRL    4'h0
`define KP_REG_STATUS  4'h4
`define KP_REG_DATA    4'h8

`endif

/* common/keypad_pkg.sv */
// ----------------------------
// keypad side types, key codes follow the phone layout (star 10, hash 11)
// ----------------------------
`default_nettype none

package keypad_pkg;

  // ----------------------------
  // key codes
  typedef enum logic [3:0] {
    key_0    = 4'd0,
    key_1    = 4'd1,
    key_2    = 4'd2,
    key_3    = 4'd3,
    key_4    = 4'd4,
    key_5    = 4'd5,
    key_6    = 4'd6,
    key_7    = 4'd7,
    key_8    = 4'd8,
    key_9    = 4'd9,
    key_star = 4'd10,
    key_hash = 4'd11
  } key_code_e;

  // ----------------------------
  // row scanner
  typedef enum logic [1:0] {
    idle   = 2'd0,
    drive  = 2'd1,  // row low, waiting on cols
    sample = 2'd2   // last dwell clock
  } scan_state_e;

  // result of one full sweep of the matrix
  typedef struct packed {
    logic      done;  // one clock per sweep
    logic      hit;   // exactly one key down
    key_code_e code;
  } sweep_t;

  // debounced press, valid is a one clock push
  typedef struct packed {
    logic      valid;
    key_code_e code;
  } key_event_t;

endpackage

`default_nettype wire

/* keypad/key_debounce.sv */
// ----------------------------
// counts whole sweeps, one event per press; needs a no-hit sweep to re-arm
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keypad_defs.svh"

module key_debounce (
  input  logic                    pclk,
  input  logic                    rst,
  input  logic                    scan_en,
  input  keypad_pkg::sweep_t      sweep,
  output keypad_pkg::key_event_t  evt
);
  import keypad_pkg::*;

  localparam int CNT_W = $clog2(`KP_DEBOUNCE + 1);

  key_code_e          last_code;
  logic [CNT_W-1:0]   stable_cnt;
  logic [CNT_W-1:0]   cnt_nxt;
  logic               fired;       // event already sent for this press

  // ----------------------------
  // stable sweep count
  always_comb begin
    if (sweep.hit && sweep.code == last_code && stable_cnt != '0) begin
      if (stable_cnt == CNT_W'(`KP_DEBOUNCE))
        cnt_nxt = stable_cnt;          // hold at limit
      else
        cnt_nxt = stable_cnt + 1'b1;
    end else if (sweep.hit) begin
      cnt_nxt = CNT_W'(1);             // new key, start over
    end else begin
      cnt_nxt = '0;
    end
  end

  // ----------------------------
  // history and event
  always_ff @(posedge pclk) begin
    if (rst) begin
      last_code  <= key_0;
      stable_cnt <= '0;
      fired      <= 1'b0;
      evt        <= '0;
    end else begin
      evt.valid <= 1'b0;
      if (!scan_en) begin
        stable_cnt <= '0;  // held key counts again after re-enable
        fired      <= 1'b0;
      end else if (sweep.done) begin
        stable_cnt <= cnt_nxt;
        last_code  <= sweep.code;
        if (!sweep.hit) begin
          fired <= 1'b0;
        end else if (cnt_nxt == CNT_W'(`KP_DEBOUNCE) && !fired) begin
          evt.valid <= 1'b1;
          evt.code  <= sweep.code;
          fired     <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* keypad/keypad_scan.sv */
// ----------------------------
// cols are active low and synchronized here; more than one key in a sweep is no hit
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keypad_defs.svh"

module keypad_scan (
  input  logic                  pclk,
  input  logic                  rst,
  input  logic                  scan_en,
  input  logic [`KP_COLS-1:0]   cols,
  output logic [`KP_ROWS-1:0]   rows,
  output keypad_pkg::sweep_t    sweep
);
  import keypad_pkg::*;

  localparam int ROW_W   = $clog2(`KP_ROWS);
  localparam int DWELL_W = $clog2(`KP_DWELL);

  scan_state_e          state;
  logic [ROW_W-1:0]     row_idx;
  logic [DWELL_W-1:0]   dwell;
  logic [`KP_COLS-1:0]  cols_meta;
  logic [`KP_COLS-1:0]  cols_sync;
  logic [1:0]           key_cnt;      // saturates at 2
  key_code_e            code_acc;
  logic [1:0]           lows;
  logic [2:0]           cnt_sum;
  logic [1:0]           key_cnt_nxt;
  key_code_e            code_nxt;

  // low col count where 2 means several
  function automatic logic [1:0] count_low(input logic [`KP_COLS-1:0] c);
    case (c)
      3'b111:                 count_low = 2'd0;
      3'b110, 3'b101, 3'b011: count_low = 2'd1;
      default:                count_low = 2'd2;
    endcase
  endfunction

  // phone layout with col 0 on bit 0
  function automatic key_code_e map_key(input logic [ROW_W-1:0] r,
                                        input logic [`KP_COLS-1:0] c);
    logic [1:0] col;
    col = (c == 3'b110) ? 2'd0 : (c == 3'b101) ? 2'd1 : 2'd2;
    case (r)
      2'd0:    map_key = key_code_e'(4'd1 + col);
      2'd1:    map_key = key_code_e'(4'd4 + col);
      2'd2:    map_key = key_code_e'(4'd7 + col);
      default: map_key = (col == 2'd0) ? key_star : (col == 2'd1) ? key_0 : key_hash;
    endcase
  endfunction

  // ----------------------------
  // column synchronizer
  always_ff @(posedge pclk) begin
    cols_meta <= cols;
    cols_sync <= cols_meta;
  end

  assign lows        = count_low(cols_sync);
  assign cnt_sum     = {1'b0, key_cnt} + {1'b0, lows};
  assign key_cnt_nxt = (cnt_sum > 3'd2) ? 2'd2 : cnt_sum[1:0];
  assign code_nxt    = (lows == 2'd1) ? map_key(row_idx, cols_sync) : code_acc;

  // ----------------------------
  // scan fsm
  always_ff @(posedge pclk) begin
    if (rst) begin
      state    <= idle;
      row_idx  <= '0;
      dwell    <= '0;
      key_cnt  <= '0;
      code_acc <= key_0;
      sweep    <= '0;
    end else begin
      sweep.done <= 1'b0;
      if (!scan_en) begin
        state   <= idle;  // drop the sweep in progress
        row_idx <= '0;
        dwell   <= '0;
        key_cnt <= '0;
      end else begin
        case (state)
          idle: begin
            state   <= drive;
            row_idx <= '0;
            dwell   <= '0;
            key_cnt <= '0;
          end
          drive: begin
            dwell <= dwell + 1'b1;
            if (dwell == DWELL_W'(`KP_DWELL - 2)) state <= sample;
          end
          sample: begin
            state   <= drive;
            dwell   <= '0;
            row_idx <= row_idx + 1'b1;  // wraps after last row
            if (row_idx == ROW_W'(`KP_ROWS - 1)) begin
              sweep.done <= 1'b1;
              sweep.hit  <= (key_cnt_nxt == 2'd1);
              sweep.code <= code_nxt;
              key_cnt    <= '0;
            end else begin
              key_cnt  <= key_cnt_nxt;
              code_acc <= code_nxt;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  assign rows = (state == idle) ? '1 : ~(`KP_ROWS'(1) << row_idx);

  // all rows released the clock after enable drops
  a_rows_off: assert property (@(posedge pclk) disable iff (rst)
    !scan_en |=> rows == '1);

endmodule

`default_nettype wire

/* keypad_ctrl.f */
+incdir+common
common/keypad_pkg.sv
common/apb_pkg.sv
keypad/keypad_scan.sv
keypad/key_debounce.sv
rtl/key_fifo.sv
rtl/keypad_ctrl.sv
rtl/keypad_top.sv
testbench/keypad_matrix_model.sv
testbench/tb_keypad_top.sv

/* rtl/key_fifo.sv */
// ----------------------------
// push when full is dropped and sets ovf, oldest entries kept
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keypad_defs.svh"

module key_fifo (
  input  logic                    pclk,
  input  logic                    rst,
  input  keypad_pkg::key_event_t  evt,
  input  logic                    pop,
  input  logic                    clr_ovf,
  output keypad_pkg::key_event_t  head,
  output logic [`KP_FIFO_AW:0]    count,
  output logic                    ovf
);
  import keypad_pkg::*;

  localparam int CNT_W = `KP_FIFO_AW + 1;

  key_code_e                mem [`KP_FIFO_DEPTH];
  logic [`KP_FIFO_AW-1:0]   wr_ptr;
  logic [`KP_FIFO_AW-1:0]   rd_ptr;
  logic                     full;
  logic                     do_push;
  logic                     do_pop;

  assign full    = (count == CNT_W'(`KP_FIFO_DEPTH));
  assign do_pop  = pop && (count != '0);
  assign do_push = evt.valid && (!full || do_pop);  // pop frees a slot this cycle

  // storage
  always_ff @(posedge pclk) begin
    if (do_push) mem[wr_ptr] <= evt.code;
  end

  // ----------------------------
  // pointers, count, overflow
  always_ff @(posedge pclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf    <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      ovf <= (ovf && !clr_ovf) || (evt.valid && !do_push);  // new drop wins over clear
    end
  end

  assign head.valid = (count != '0);
  assign head.code  = mem[rd_ptr];

  a_count_max: assert property (@(posedge pclk) disable iff (rst)
    count <= CNT_W'(`KP_FIFO_DEPTH));

endmodule

`default_nettype wire

/* rtl/keypad_ctrl.sv */
// ----------------------------
// no wait states; writes to DATA and unmapped offsets give pslverr
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keypad_defs.svh"

module keypad_ctrl (
  input  logic                    pclk,
  input  logic                    rst,
  input  apb_pkg::apb_req_t       apb_req,
  output apb_pkg::apb_rsp_t       apb_rsp,
  input  keypad_pkg::key_event_t  head,     // valid means fifo not empty
  input  logic [`KP_FIFO_AW:0]    count,
  input  logic                    ovf,
  output logic                    scan_en,
  output logic                    pop,
  output logic                    clr_ovf,
  output logic                    irq
);
  import apb_pkg::*;

  reg_sel_e sel;
  logic     access;
  logic     wr;
  logic     rd;
  logic     enable;
  logic     irq_en;

  // ----------------------------
  // address decode
  always_comb begin
    case (apb_req.paddr)
      `KP_REG_CTRL:   sel = ctrl;
      `KP_REG_STATUS: sel = status;
      `KP_REG_DATA:   sel = data;
      default:        sel = none;
    endcase
  end

  assign access = apb_req.psel && apb_req.penable;  // access phase only
  assign wr     = access && apb_req.pwrite;
  assign rd     = access && !apb_req.pwrite;

  // ----------------------------
  // read data and error
  always_comb begin
    apb_rsp.prdata  = '0;
    apb_rsp.pslverr = 1'b0;
    if (access) begin
      case (sel)
        ctrl: begin
          if (rd) apb_rsp.prdata[1:0] = {irq_en, enable};
        end
        status: begin
          if (rd) begin
            apb_rsp.prdata[`KP_FIFO_AW:0] = count;
            apb_rsp.prdata[8]             = ovf;
          end
        end
        data: begin
          if (wr) begin
            apb_rsp.pslverr = 1'b1;    // read only
          end else if (head.valid) begin
            apb_rsp.prdata[8]   = 1'b1;
            apb_rsp.prdata[3:0] = head.code;
          end
        end
        default: apb_rsp.pslverr = 1'b1;
      endcase
    end
  end

  assign pop     = rd && (sel == data) && head.valid;
  assign clr_ovf = wr && (sel == status) && apb_req.pwdata[8];
  assign scan_en = enable;

  // ----------------------------
  // control bits and irq
  always_ff @(posedge pclk) begin
    if (rst) begin
      enable <= 1'b0;
      irq_en <= 1'b0;
      irq    <= 1'b0;
    end else begin
      if (wr && sel == ctrl) begin
        enable <= apb_req.pwdata[0];
        irq_en <= apb_req.pwdata[1];
      end
      irq <= irq_en && head.valid;  // one clock behind fifo state
    end
  end

  // fifo count must agree with head.valid
  a_pop_needs_data: assert property (@(posedge pclk) disable iff (rst)
    pop |-> count != '0);

endmodule

`default_nettype wire

/* rtl/keypad_top.sv */
// ----------------------------
// pready is implied high; rows and cols are active low keypad pins
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keypad_defs.svh"

module keypad_top (
  input  logic                  pclk,
  input  logic                  rst,
  input  apb_pkg::apb_req_t     apb_req,
  output apb_pkg::apb_rsp_t     apb_rsp,
  input  logic [`KP_COLS-1:0]   cols,
  output logic [`KP_ROWS-1:0]   rows,
  output logic                  irq
);
  import keypad_pkg::*;

  logic                   scan_en;
  logic                   pop;
  logic                   clr_ovf;
  sweep_t                 sweep;
  key_event_t             evt;
  key_event_t             head;
  logic [`KP_FIFO_AW:0]   count;
  logic                   ovf;

  keypad_ctrl i_ctrl (
    .pclk    (pclk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .head    (head),
    .count   (count),
    .ovf     (ovf),
    .scan_en (scan_en),
    .pop     (pop),
    .clr_ovf (clr_ovf),
    .irq     (irq)
  );

  keypad_scan i_scan (
    .pclk    (pclk),
    .rst     (rst),
    .scan_en (scan_en),
    .cols    (cols),
    .rows    (rows),
    .sweep   (sweep)
  );

  key_debounce i_debounce (
    .pclk    (pclk),
    .rst     (rst),
    .scan_en (scan_en),
    .sweep   (sweep),
    .evt     (evt)
  );

  key_fifo i_fifo (
    .pclk    (pclk),
    .rst     (rst),
    .evt     (evt),
    .pop     (pop),
    .clr_ovf (clr_ovf),
    .head    (head),
    .count   (count),
    .ovf     (ovf)
  );

endmodule

`default_nettype wire

/* testbench/keypad_matrix_model.sv */
// ----------------------------
// ideal switches, no bounce; held bit index is row*cols + col
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keypad_defs.svh"

module keypad_matrix_model (
  input  logic [`KP_ROWS-1:0]           rows,  // active low from the DUT
  input  logic [`KP_ROWS*`KP_COLS-1:0]  held,
  output logic [`KP_COLS-1:0]           cols
);

  // ----------------------------
  // a held key shorts its row to its col
  always_comb begin
    cols = '1;  // pull-ups
    for (int r = 0; r < `KP_ROWS; r++) begin
      for (int c = 0; c < `KP_COLS; c++) begin
        if (held[r*`KP_COLS + c] && !rows[r]) cols[c] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_keypad_top.sv */
// ----------------------------
// expected values carry pslverr in bit 32; the keypad model has no bounce
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

`include "keypad_defs.svh"

module tb_keypad_top;
  import apb_pkg::*;

  localparam int KEYS  = `KP_ROWS * `KP_COLS;
  localparam int SWEEP = `KP_ROWS * `KP_DWELL;  // clocks per sweep
  localparam int GAP   = 3;                     // idle sweeps after release
  // phone layout by position with star 0 hash in the last row
  localparam logic [3:0] REF_CODE [12] = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6,
                                           4'd7, 4'd8, 4'd9, 4'd10, 4'd0, 4'd11};

  typedef enum {op_read, op_enable, op_clear, op_press, op_press_short,
                op_press_pair, op_disable_press} op_e;

  typedef struct {
    string       name;
    op_e         op;
    logic [11:0] key;   // held mask or register offset for reads
    int          hold;  // sweeps
    logic [32:0] exp;
  } entry_t;

  logic                 pclk;
  logic                 rst;
  apb_req_t             apb_req;
  apb_rsp_t             apb_rsp;
  logic [`KP_COLS-1:0]  cols;
  logic [`KP_ROWS-1:0]  rows;
  logic                 irq;
  logic [KEYS-1:0]      held;
  logic [31:0]          ctrl_val;
  integer               seed;
  entry_t               tests [$];

  keypad_top i_dut (
    .pclk    (pclk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .cols    (cols),
    .rows    (rows),
    .irq     (irq)
  );

  keypad_matrix_model i_keypad (.rows(rows), .held(held), .cols(cols));

  always #2 pclk = ~pclk;

  // ----------------------------
  // checking helpers
  task automatic fail_now(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [32:0] exp,
                             input logic [32:0] act);
    assert (act === exp) else begin
      $display("Error: %s expected %0h actual %0h", name, exp, act);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // one transfer with inputs changing on the falling edge
  task automatic apb_xfer(input logic wr, input logic [3:0] addr,
                          input logic [31:0] wdata, output logic [32:0] rsp);
    @(negedge pclk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge pclk);
    apb_req.penable = 1'b1;
    #1;
    rsp = {apb_rsp.pslverr, apb_rsp.prdata};  // settled before the posedge
    @(negedge pclk);
    apb_req = '0;
  endtask

  task automatic hold_keys(input logic [11:0] mask, input int sweeps,
                           input logic rows_idle, input string name);
    @(negedge pclk);
    held = mask;
    repeat (sweeps * SWEEP) begin
      @(negedge pclk);
      if (rows_idle) check_value(name, 33'hf, 33'(rows));
    end
    held = '0;
    repeat (GAP * SWEEP) @(negedge pclk);
  endtask

  task automatic wait_count(input string name, input logic [2:0] exp);
    logic [32:0] rsp;
    for (int tries = 0; tries < 40; tries++) begin
      apb_xfer(1'b0, `KP_REG_STATUS, '0, rsp);
      if (rsp[2:0] == exp) break;
    end
    if (rsp[2:0] != exp) fail_now($sformatf("timeout: fifo count never reached %0d in %s",
                                            exp, name));
  endtask

  task automatic wait_irq(input string name);
    for (int tries = 0; tries < 20 && irq !== 1'b1; tries++) @(negedge pclk);
    if (irq !== 1'b1) fail_now($sformatf("timeout: irq did not rise in %s", name));
  endtask

  // ----------------------------
  // stimulus table
  function automatic void add_entry(input string name, input op_e op, input logic [11:0] key,
                                    input int hold, input logic [32:0] exp);
    entry_t e;
    e.name = name;
    e.op   = op;
    e.key  = key;
    e.hold = hold;
    e.exp  = exp;
    tests.push_back(e);
  endfunction

  function automatic void build_tests();
    int rnd [5];
    for (int i = 0; i < 5; i++) rnd[i] = $unsigned($random(seed)) % KEYS;
    add_entry("reset_status", op_read, 12'(`KP_REG_STATUS), 0, 33'h0);
    add_entry("reset_data", op_read, 12'(`KP_REG_DATA), 0, 33'h0);
    add_entry("unmapped", op_read, 12'hc, 0, 33'h1_0000_0000);
    add_entry("enable", op_enable, '0, 0, 33'h3);
    for (int p = 0; p < KEYS; p++) begin
      add_entry($sformatf("press_%0d", p), op_press, 12'(1 << p), 6, 33'd1);
      add_entry($sformatf("data_%0d", p), op_read, 12'(`KP_REG_DATA), 0,
                33'h100 | 33'(REF_CODE[p]));
    end
    add_entry("short_press", op_press_short, 12'h010, 1, 33'h0);
    add_entry("pair_one_row", op_press_pair, 12'h018, 6, 33'h0);  // keys 4 and 5
    add_entry("pair_two_rows", op_press_pair, 12'h081, 6, 33'h0);  // keys 1 and 8
    add_entry("disabled", op_disable_press, 12'h100, 6, 33'h0);
    for (int i = 0; i < 5; i++)
      add_entry($sformatf("rand_press_%0d", i), op_press, 12'(1 << rnd[i]), 6,
                (i < 4) ? 33'(i + 1) : 33'd4);
    add_entry("ovf_status", op_read, 12'(`KP_REG_STATUS), 0, 33'h104);
    for (int i = 0; i < 4; i++)
      add_entry($sformatf("rand_data_%0d", i), op_read, 12'(`KP_REG_DATA), 0,
                33'h100 | 33'(REF_CODE[rnd[i]]));
    add_entry("clear_ovf", op_clear, '0, 0, 33'h0);
    add_entry("empty_data", op_read, 12'(`KP_REG_DATA), 0, 33'h0);
  endfunction

  task automatic apply_entry(input entry_t e);
    logic [32:0] rsp;
    case (e.op)
      op_read: begin
        apb_xfer(1'b0, e.key[3:0], '0, rsp);
        check_value(e.name, e.exp, rsp);
      end
      op_enable: begin
        ctrl_val = e.exp[31:0];
        apb_xfer(1'b1, `KP_REG_CTRL, ctrl_val, rsp);
        apb_xfer(1'b0, `KP_REG_CTRL, '0, rsp);
        check_value(e.name, e.exp, rsp);
      end
      op_clear: begin
        apb_xfer(1'b1, `KP_REG_STATUS, 32'h100, rsp);
        apb_xfer(1'b0, `KP_REG_STATUS, '0, rsp);
        check_value(e.name, e.exp, rsp);
      end
      op_press: begin
        if (ctrl_val[1] && e.exp[2:0] == 3'd1) begin
          @(negedge pclk);
          check_value(e.name, 33'h0, 33'(irq));  // fifo empty so irq starts low
        end
        hold_keys(e.key, e.hold, 1'b0, e.name);
        wait_count(e.name, e.exp[2:0]);
        if (ctrl_val[1]) wait_irq(e.name);
      end
      op_disable_press: begin
        apb_xfer(1'b1, `KP_REG_CTRL, 32'h0, rsp);
        hold_keys(e.key, e.hold, 1'b1, e.name);  // rows must stay high
        apb_xfer(1'b1, `KP_REG_CTRL, ctrl_val, rsp);
        apb_xfer(1'b0, `KP_REG_STATUS, '0, rsp);
        check_value(e.name, e.exp, rsp);
      end
      default: begin  // short press and pairs leave the fifo alone
        hold_keys(e.key, e.hold, 1'b0, e.name);
        apb_xfer(1'b0, `KP_REG_STATUS, '0, rsp);
        check_value(e.name, e.exp, rsp);
      end
    endcase
  endtask

  // ----------------------------
  initial begin
    pclk     = 1'b0;
    rst      = 1'b1;
    apb_req  = '0;
    held     = '0;
    ctrl_val = '0;
    seed     = 32'hf055;
    build_tests();
    repeat (3) @(posedge pclk);
    @(negedge pclk);
    rst = 1'b0;
    check_value("reset_irq", 33'h0, 33'(irq));
    foreach (tests[i]) apply_entry(tests[i]);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
